// File: outbuf_pkg.sv
package outbuf_pkg;

  // Default element width in bits
  parameter int unsigned DATA_W = 16;

  // Default tile geometry
  // Columns match the array lanes, rows match the pipeline depth
  parameter int unsigned ARRAY_W = 4;
  parameter int unsigned ARRAY_D = 4;

  // Width of the runtime size fields, values run from 1 up to the geometry
  parameter int unsigned SIZE_W = 4;

  // Buffer phases
  // EMPTY   waiting for bias columns or result rows
  // LOADED  bias tile is complete and can be pushed
  // PUSHED  result tile is complete and waits to be stored
  typedef enum logic [1:0] {
    EMPTY  = 2'd0,
    LOADED = 2'd1,
    PUSHED = 2'd2
  } buf_state_e;

endpackage : outbuf_pkg

// File: outbuf_ctrl_if.sv
`timescale 1ns/1ps

interface outbuf_ctrl_if #(
  parameter int unsigned SizeW = outbuf_pkg::SIZE_W
) ();

  // Strobes from the host side
  logic             fill;
  logic             y_valid;
  logic             ready;
  logic             y_push_enable;
  logic             first_load;

  // Runtime tile sizes
  logic [SizeW-1:0] y_width;
  logic [SizeW-1:0] y_height;
  logic [SizeW-1:0] z_width;
  logic [SizeW-1:0] z_height;

  // Answers and status from the buffer controller
  logic             y_ready;
  logic             z_valid;
  logic             loaded;
  logic             y_pushed;
  logic             empty;

  modport ctrl (
    input  fill,
    input  y_valid,
    input  ready,
    input  y_push_enable,
    input  first_load,
    input  y_width,
    input  y_height,
    input  z_width,
    input  z_height,
    output y_ready,
    output z_valid,
    output loaded,
    output y_pushed,
    output empty
  );

  modport host (
    output fill,
    output y_valid,
    output ready,
    output y_push_enable,
    output first_load,
    output y_width,
    output y_height,
    output z_width,
    output z_height,
    input  y_ready,
    input  z_valid,
    input  loaded,
    input  y_pushed,
    input  empty
  );

endinterface : outbuf_ctrl_if

// File: outbuf_scm.sv
`timescale 1ns/1ps

module outbuf_scm #(
  parameter int unsigned DataW = outbuf_pkg::DATA_W,
  parameter int unsigned Rows  = outbuf_pkg::ARRAY_D,
  parameter int unsigned Cols  = outbuf_pkg::ARRAY_W,
  localparam int unsigned RowAw = (Rows > 1) ? $clog2(Rows) : 1,
  localparam int unsigned ColAw = (Cols > 1) ? $clog2(Cols) : 1
) (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       clear_i,
  input  logic                       row_we_i,
  input  logic                       col_we_i,
  input  logic [RowAw-1:0]           row_waddr_i,
  input  logic [ColAw-1:0]           col_waddr_i,
  input  logic [Cols-1:0][DataW-1:0] row_wdata_i,
  input  logic [Rows-1:0][DataW-1:0] col_wdata_i,
  input  logic [RowAw-1:0]           row_raddr_i,
  input  logic [ColAw-1:0]           col_raddr_i,
  output logic [Cols-1:0][DataW-1:0] row_rdata_o,
  output logic [Rows-1:0][DataW-1:0] col_rdata_o
);

  // Word array, first index is the row
  logic [Rows-1:0][Cols-1:0][DataW-1:0] mem_q;

  // Row writes fill one row, column writes touch one word per row
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mem_q <= '0;
    end else if (clear_i) begin
      mem_q <= '0;
    end else if (row_we_i) begin
      mem_q[row_waddr_i] <= row_wdata_i;
    end else if (col_we_i) begin
      for (int unsigned r = 0; r < Rows; r++) begin
        mem_q[r][col_waddr_i] <= col_wdata_i[r];
      end
    end
  end

  // Row read port
  always_comb begin
    row_rdata_o = mem_q[row_raddr_i];
  end

  // Column read port gathers one word from every row, which is the transpose
  always_comb begin
    for (int unsigned r = 0; r < Rows; r++) begin
      col_rdata_o[r] = mem_q[r][col_raddr_i];
    end
  end

  // Both write ports share the array, the controller keeps them apart
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(row_we_i && col_we_i))
    else $error("outbuf_scm: row and column write in the same cycle");

endmodule : outbuf_scm

// File: outbuf_tile.sv
`timescale 1ns/1ps

module outbuf_tile #(
  parameter int unsigned DataW = outbuf_pkg::DATA_W,
  parameter int unsigned Width = outbuf_pkg::ARRAY_W,
  parameter int unsigned Depth = outbuf_pkg::ARRAY_D,
  localparam int unsigned StrbW = Depth * (DataW / 8)
) (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        clear_i,
  outbuf_ctrl_if.ctrl                 ctrl,
  input  logic [Width-1:0][DataW-1:0] z_row_i,
  input  logic [Depth-1:0][DataW-1:0] y_col_i,
  output logic [Depth-1:0][DataW-1:0] z_data_o,
  output logic [Width-1:0][DataW-1:0] y_data_o,
  output logic [StrbW-1:0]            z_strb_o
);

  import outbuf_pkg::*;

  localparam int unsigned RowAw = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int unsigned ColAw = (Width > 1) ? $clog2(Width) : 1;
  localparam int unsigned WordB = DataW / 8;

  buf_state_e state_q, state_d;

  // Position counters
  // col_cnt   bias column being loaded
  // push_cnt  bias row being pushed into the array
  // fill_cnt  result row being written
  // store_cnt result column being stored
  logic [ColAw-1:0] col_cnt_q;
  logic [RowAw-1:0] push_cnt_q;
  logic [RowAw-1:0] fill_cnt_q;
  logic [ColAw-1:0] store_cnt_q;

  logic load_en;
  logic store_en;
  logic col_acc;
  logic store_acc;
  logic col_last;
  logic push_last;
  logic fill_last;
  logic store_last;

  // A bias column must not land while result rows arrive or biases
  // are still being pushed out of the previous load
  assign load_en   = (state_q == EMPTY) && !ctrl.fill && (push_cnt_q == '0);
  assign store_en  = (state_q == PUSHED);
  assign col_acc   = load_en && ctrl.y_valid;
  assign store_acc = store_en && ctrl.ready;

  // End of phase detection against the runtime sizes
  assign col_last   = col_acc && (SIZE_W'(col_cnt_q) == ctrl.y_width - SIZE_W'(1));
  assign push_last  = ctrl.y_push_enable &&
                      (SIZE_W'(push_cnt_q) == ctrl.y_height - SIZE_W'(1));
  assign fill_last  = ctrl.fill && (SIZE_W'(fill_cnt_q) == ctrl.z_height - SIZE_W'(1));
  assign store_last = store_acc && (SIZE_W'(store_cnt_q) == ctrl.z_width - SIZE_W'(1));

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= EMPTY;
    end else if (clear_i) begin
      state_q <= EMPTY;
    end else begin
      state_q <= state_d;
    end
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      EMPTY: begin
        if (col_last) begin
          state_d = LOADED;
        end
        // Last fill wins and also covers a tile of height one
        if (fill_last) begin
          state_d = PUSHED;
        end
      end
      LOADED: begin
        if (push_last) begin
          state_d = EMPTY;
        end
        if (fill_last) begin
          state_d = PUSHED;
        end
      end
      PUSHED: begin
        if (store_last) begin
          state_d = EMPTY;
        end
      end
      default: begin
        state_d = EMPTY;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      col_cnt_q <= '0;
    end else if (clear_i || col_last) begin
      col_cnt_q <= '0;
    end else if (col_acc) begin
      col_cnt_q <= col_cnt_q + 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      push_cnt_q <= '0;
    end else if (clear_i || push_last) begin
      push_cnt_q <= '0;
    end else if (ctrl.y_push_enable) begin
      push_cnt_q <= push_cnt_q + 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      fill_cnt_q <= '0;
    end else if (clear_i || fill_last) begin
      fill_cnt_q <= '0;
    end else if (ctrl.fill) begin
      fill_cnt_q <= fill_cnt_q + 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      store_cnt_q <= '0;
    end else if (clear_i || store_last) begin
      store_cnt_q <= '0;
    end else if (store_acc) begin
      store_cnt_q <= store_cnt_q + 1'b1;
    end
  end

  // Handshake answers and status
  assign ctrl.y_ready  = col_acc;
  assign ctrl.z_valid  = store_acc;
  assign ctrl.y_pushed = push_last;
  assign ctrl.loaded   = (state_q == LOADED) || col_last;
  // A first tile has no earlier result to store, so the push frees it
  assign ctrl.empty    = store_last ||
                         ((state_q == LOADED) && push_last && ctrl.first_load);

  // Byte enables cover the valid height of a store column
  always_comb begin
    z_strb_o = '0;
    for (int i = 0; i < int'(Depth); i++) begin
      if (i < int'(ctrl.z_height)) begin
        z_strb_o[i*WordB +: WordB] = '1;
      end
    end
  end

  outbuf_scm #(
    .DataW ( DataW ),
    .Rows  ( Depth ),
    .Cols  ( Width )
  ) i_scm (
    .clk_i       ( clk_i       ),
    .rst_ni      ( rst_ni      ),
    .clear_i     ( clear_i     ),
    .row_we_i    ( ctrl.fill   ),
    .col_we_i    ( col_acc     ),
    .row_waddr_i ( fill_cnt_q  ),
    .col_waddr_i ( col_cnt_q   ),
    .row_wdata_i ( z_row_i     ),
    .col_wdata_i ( y_col_i     ),
    .row_raddr_i ( push_cnt_q  ),
    .col_raddr_i ( store_cnt_q ),
    .row_rdata_o ( y_data_o    ),
    .col_rdata_o ( z_data_o    )
  );

  // Stores only leave a finished result tile
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    ctrl.z_valid |-> (state_q == PUSHED))
    else $error("outbuf_tile: z_valid outside PUSHED");

  assert property (@(posedge clk_i) disable iff (!rst_ni)
    ctrl.fill |-> !ctrl.y_ready)
    else $error("outbuf_tile: bias accepted during fill");

  assert property (@(posedge clk_i) disable iff (!rst_ni)
    state_q inside {EMPTY, LOADED, PUSHED})
    else $error("outbuf_tile: illegal state");

endmodule : outbuf_tile

// File: outbuf_top.sv
`timescale 1ns/1ps

module outbuf_top #(
  parameter int unsigned DataW = outbuf_pkg::DATA_W,
  parameter int unsigned Width = outbuf_pkg::ARRAY_W,
  parameter int unsigned Depth = outbuf_pkg::ARRAY_D,
  localparam int unsigned StrbW = Depth * (DataW / 8)
) (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  logic                            clear_i,
  input  logic                            fill_i,
  input  logic                            y_valid_i,
  input  logic                            ready_i,
  input  logic                            y_push_enable_i,
  input  logic                            first_load_i,
  input  logic [outbuf_pkg::SIZE_W-1:0]   y_width_i,
  input  logic [outbuf_pkg::SIZE_W-1:0]   y_height_i,
  input  logic [outbuf_pkg::SIZE_W-1:0]   z_width_i,
  input  logic [outbuf_pkg::SIZE_W-1:0]   z_height_i,
  input  logic [Width-1:0][DataW-1:0]     z_row_i,
  input  logic [Depth-1:0][DataW-1:0]     y_col_i,
  output logic [Depth-1:0][DataW-1:0]     z_data_o,
  output logic [Width-1:0][DataW-1:0]     y_data_o,
  output logic [StrbW-1:0]                z_strb_o,
  output logic                            y_ready_o,
  output logic                            z_valid_o,
  output logic                            loaded_o,
  output logic                            y_pushed_o,
  output logic                            empty_o
);

  import outbuf_pkg::*;

  outbuf_ctrl_if #(.SizeW(SIZE_W)) ctrl_bus ();

  // Host side of the control bundle
  assign ctrl_bus.fill          = fill_i;
  assign ctrl_bus.y_valid       = y_valid_i;
  assign ctrl_bus.ready         = ready_i;
  assign ctrl_bus.y_push_enable = y_push_enable_i;
  assign ctrl_bus.first_load    = first_load_i;
  assign ctrl_bus.y_width       = y_width_i;
  assign ctrl_bus.y_height      = y_height_i;
  assign ctrl_bus.z_width       = z_width_i;
  assign ctrl_bus.z_height      = z_height_i;

  assign y_ready_o  = ctrl_bus.y_ready;
  assign z_valid_o  = ctrl_bus.z_valid;
  assign loaded_o   = ctrl_bus.loaded;
  assign y_pushed_o = ctrl_bus.y_pushed;
  assign empty_o    = ctrl_bus.empty;

  outbuf_tile #(
    .DataW ( DataW ),
    .Width ( Width ),
    .Depth ( Depth )
  ) i_tile (
    .clk_i    ( clk_i         ),
    .rst_ni   ( rst_ni        ),
    .clear_i  ( clear_i       ),
    .ctrl     ( ctrl_bus.ctrl ),
    .z_row_i  ( z_row_i       ),
    .y_col_i  ( y_col_i       ),
    .z_data_o ( z_data_o      ),
    .y_data_o ( y_data_o      ),
    .z_strb_o ( z_strb_o      )
  );

endmodule : outbuf_top

// File: outbuf_tb.sv
`timescale 1ns/1ps

module outbuf_tb;

  import outbuf_pkg::*;

  localparam int unsigned DataW       = DATA_W;
  localparam int unsigned Width       = ARRAY_W;
  localparam int unsigned Depth       = ARRAY_D;
  localparam int unsigned WordB       = DataW / 8;
  localparam int unsigned StrbW       = Depth * WordB;
  localparam int unsigned CheckW      = 256;
  localparam int          SeedInit    = 26;
  localparam int unsigned NumTiles    = 8;
  localparam int unsigned WaitLimit   = 64;
  localparam int unsigned CycleBudget = 5000;

  logic                        clk_i;
  logic                        rst_ni;
  logic                        clear_i;
  logic                        fill_i;
  logic                        y_valid_i;
  logic                        ready_i;
  logic                        y_push_enable_i;
  logic                        first_load_i;
  logic [SIZE_W-1:0]           y_width_i;
  logic [SIZE_W-1:0]           y_height_i;
  logic [SIZE_W-1:0]           z_width_i;
  logic [SIZE_W-1:0]           z_height_i;
  logic [Width-1:0][DataW-1:0] z_row_i;
  logic [Depth-1:0][DataW-1:0] y_col_i;
  logic [Depth-1:0][DataW-1:0] z_data_o;
  logic [Width-1:0][DataW-1:0] y_data_o;
  logic [StrbW-1:0]            z_strb_o;
  logic                        y_ready_o;
  logic                        z_valid_o;
  logic                        loaded_o;
  logic                        y_pushed_o;
  logic                        empty_o;

  // Reference model of the tile contents and the controller
  logic [DataW-1:0] mem_m [Depth][Width];
  buf_state_e       state_m;
  int               col_m;
  int               push_m;
  int               fill_m;
  int               store_m;

  // Expected responses for the current cycle
  logic                        exp_col_acc;
  logic                        exp_store_acc;
  logic                        exp_col_last;
  logic                        exp_push_last;
  logic                        exp_fill_last;
  logic                        exp_store_last;
  logic                        exp_loaded;
  logic                        exp_empty;
  logic [Width-1:0][DataW-1:0] exp_y;
  logic [Depth-1:0][DataW-1:0] exp_z;
  logic [StrbW-1:0]            exp_strb;

  // Flags as seen at the last sample point
  logic  seen_ready;
  logic  seen_valid;
  logic  seen_loaded;
  logic  seen_pushed;
  logic  seen_empty;
  int    seed;
  string test_name;

  always #2 clk_i = ~clk_i;

  outbuf_top #(
    .DataW ( DataW ),
    .Width ( Width ),
    .Depth ( Depth )
  ) dut (
    .clk_i           ( clk_i           ),
    .rst_ni          ( rst_ni          ),
    .clear_i         ( clear_i         ),
    .fill_i          ( fill_i          ),
    .y_valid_i       ( y_valid_i       ),
    .ready_i         ( ready_i         ),
    .y_push_enable_i ( y_push_enable_i ),
    .first_load_i    ( first_load_i    ),
    .y_width_i       ( y_width_i       ),
    .y_height_i      ( y_height_i      ),
    .z_width_i       ( z_width_i       ),
    .z_height_i      ( z_height_i      ),
    .z_row_i         ( z_row_i         ),
    .y_col_i         ( y_col_i         ),
    .z_data_o        ( z_data_o        ),
    .y_data_o        ( y_data_o        ),
    .z_strb_o        ( z_strb_o        ),
    .y_ready_o       ( y_ready_o       ),
    .z_valid_o       ( z_valid_o       ),
    .loaded_o        ( loaded_o        ),
    .y_pushed_o      ( y_pushed_o      ),
    .empty_o         ( empty_o         )
  );

  task automatic report_mismatch(string what, logic [CheckW-1:0] exp_v,
                                 logic [CheckW-1:0] act_v);
    $display("Error in %s: %s expected %0h, actual %0h", test_name, what, exp_v, act_v);
    $display("Errors found");
    $fatal(1, "stopped at the first mismatch");
  endtask

  task automatic report_stall(string what);
    $display("Timeout in %s: %s did not happen in time", test_name, what);
    $display("Errors found");
    $fatal(1, "stopped on a timeout");
  endtask

  task automatic check_value(string what, logic [CheckW-1:0] exp_v,
                             logic [CheckW-1:0] act_v);
    assert (exp_v == act_v) else report_mismatch(what, exp_v, act_v);
  endtask

  function automatic logic coin(int unsigned pct);
    return ({$random(seed)} % 100) < pct;
  endfunction

  function automatic logic [SIZE_W-1:0] random_size(int unsigned limit);
    return SIZE_W'(1 + ({$random(seed)} % limit));
  endfunction

  function automatic logic [Depth-1:0][DataW-1:0] random_column();
    logic [Depth-1:0][DataW-1:0] col;
    for (int r = 0; r < int'(Depth); r++) begin
      col[r] = DataW'($random(seed));
    end
    return col;
  endfunction

  function automatic logic [Width-1:0][DataW-1:0] random_row();
    logic [Width-1:0][DataW-1:0] row;
    for (int c = 0; c < int'(Width); c++) begin
      row[c] = DataW'($random(seed));
    end
    return row;
  endfunction

  task automatic clear_model();
    for (int r = 0; r < int'(Depth); r++) begin
      for (int c = 0; c < int'(Width); c++) begin
        mem_m[r][c] = '0;
      end
    end
    state_m = EMPTY;
    col_m   = 0;
    push_m  = 0;
    fill_m  = 0;
    store_m = 0;
  endtask

  // Acceptance rules, phase ends and read data from the model state
  task automatic predict();
    exp_col_acc    = (state_m == EMPTY) && !fill_i && (push_m == 0) && y_valid_i;
    exp_store_acc  = (state_m == PUSHED) && ready_i;
    exp_col_last   = exp_col_acc && (col_m == int'(y_width_i) - 1);
    exp_push_last  = y_push_enable_i && (push_m == int'(y_height_i) - 1);
    exp_fill_last  = fill_i && (fill_m == int'(z_height_i) - 1);
    exp_store_last = exp_store_acc && (store_m == int'(z_width_i) - 1);
    exp_loaded     = (state_m == LOADED) || exp_col_last;
    exp_empty      = exp_store_last ||
                     ((state_m == LOADED) && exp_push_last && first_load_i);
    for (int c = 0; c < int'(Width); c++) begin
      exp_y[c] = mem_m[push_m][c];
    end
    for (int r = 0; r < int'(Depth); r++) begin
      exp_z[r] = mem_m[r][store_m];
    end
    for (int b = 0; b < int'(StrbW); b++) begin
      exp_strb[b] = (b / int'(WordB)) < int'(z_height_i);
    end
  endtask

  task automatic update_model();
    if (clear_i) begin
      clear_model();
    end else begin
      if (fill_i) begin
        for (int c = 0; c < int'(Width); c++) begin
          mem_m[fill_m][c] = z_row_i[c];
        end
      end else if (exp_col_acc) begin
        for (int r = 0; r < int'(Depth); r++) begin
          mem_m[r][col_m] = y_col_i[r];
        end
      end
      case (state_m)
        EMPTY: begin
          if (exp_fill_last) state_m = PUSHED;
          else if (exp_col_last) state_m = LOADED;
        end
        LOADED: begin
          if (exp_fill_last) state_m = PUSHED;
          else if (exp_push_last) state_m = EMPTY;
        end
        PUSHED: begin
          if (exp_store_last) state_m = EMPTY;
        end
        default: state_m = EMPTY;
      endcase
      col_m   = exp_col_last ? 0 : col_m + int'(exp_col_acc);
      push_m  = exp_push_last ? 0 : push_m + int'(y_push_enable_i);
      fill_m  = exp_fill_last ? 0 : fill_m + int'(fill_i);
      store_m = exp_store_last ? 0 : store_m + int'(exp_store_acc);
    end
  endtask

  // One clock cycle, outputs compared at the falling edge
  task automatic tick();
    @(negedge clk_i);
    predict();
    check_value("y_ready", CheckW'(exp_col_acc), CheckW'(y_ready_o));
    check_value("z_valid", CheckW'(exp_store_acc), CheckW'(z_valid_o));
    check_value("loaded", CheckW'(exp_loaded), CheckW'(loaded_o));
    check_value("y_pushed", CheckW'(exp_push_last), CheckW'(y_pushed_o));
    check_value("empty", CheckW'(exp_empty), CheckW'(empty_o));
    check_value("y_data", CheckW'(exp_y), CheckW'(y_data_o));
    check_value("z_data", CheckW'(exp_z), CheckW'(z_data_o));
    check_value("z_strb", CheckW'(exp_strb), CheckW'(z_strb_o));
    seen_ready  = y_ready_o;
    seen_valid  = z_valid_o;
    seen_loaded = loaded_o;
    seen_pushed = y_pushed_o;
    seen_empty  = empty_o;
    @(posedge clk_i);
    update_model();
  endtask

  task automatic load_bias();
    int unsigned n;
    int          accepted;
    test_name   = "bias load";
    accepted    = 0;
    seen_loaded = 1'b0;
    for (n = 0; n < WaitLimit && !seen_loaded; n++) begin
      y_valid_i <= coin(70);
      y_col_i   <= random_column();
      tick();
      if (seen_ready) accepted++;
    end
    y_valid_i <= 1'b0;
    if (!seen_loaded) report_stall("loaded");
    check_value("accepted columns", CheckW'(y_width_i), CheckW'(accepted));
  endtask

  // Bias and store strobes must both bounce off a loaded tile
  task automatic reject_in_loaded();
    test_name = "rejection";
    for (int n = 0; n < 2; n++) begin
      y_valid_i <= 1'b1;
      ready_i   <= 1'b1;
      y_col_i   <= random_column();
      tick();
      check_value("refused bias", '0, CheckW'(seen_ready));
      check_value("refused store", '0, CheckW'(seen_valid));
      check_value("still loaded", CheckW'(1'b1), CheckW'(seen_loaded));
    end
    y_valid_i <= 1'b0;
    ready_i   <= 1'b0;
  endtask

  task automatic push_bias();
    int unsigned n;
    int          pushes;
    test_name   = "bias push";
    pushes      = 0;
    seen_pushed = 1'b0;
    for (n = 0; n < WaitLimit && !seen_pushed; n++) begin
      y_push_enable_i <= coin(60);
      tick();
      if (y_push_enable_i) pushes++;
    end
    y_push_enable_i <= 1'b0;
    if (!seen_pushed) report_stall("y_pushed");
    check_value("pushed rows", CheckW'(y_height_i), CheckW'(pushes));
    check_value("empty on last push", CheckW'(first_load_i), CheckW'(seen_empty));
  endtask

  task automatic fill_rows();
    int unsigned n;
    int          sent;
    logic        fire;
    test_name = "fill";
    sent      = 0;
    for (n = 0; n < WaitLimit && sent < int'(z_height_i); n++) begin
      fire = coin(70);
      fill_i    <= fire;
      z_row_i   <= random_row();
      // Bias offered together with a result row is never taken
      y_valid_i <= fire && coin(50);
      y_col_i   <= random_column();
      ready_i   <= coin(30);
      tick();
      if (fire) sent++;
    end
    fill_i    <= 1'b0;
    y_valid_i <= 1'b0;
    ready_i   <= 1'b0;
    if (sent < int'(z_height_i)) report_stall("the last fill row");
  endtask

  task automatic store_columns();
    int unsigned n;
    int          stores;
    test_name  = "store";
    stores     = 0;
    seen_empty = 1'b0;
    for (n = 0; n < WaitLimit && !seen_empty; n++) begin
      ready_i   <= coin(60);
      y_valid_i <= coin(30);
      y_col_i   <= random_column();
      tick();
      if (seen_valid) stores++;
    end
    ready_i   <= 1'b0;
    y_valid_i <= 1'b0;
    if (!seen_empty) report_stall("empty after the last store");
    check_value("stored columns", CheckW'(z_width_i), CheckW'(stores));
  endtask

  // Clear a finished result tile, then a bias column must go in at once
  task automatic clear_tile();
    z_height_i <= random_size(Depth);
    fill_rows();
    test_name = "clear";
    clear_i <= 1'b1;
    tick();
    clear_i   <= 1'b0;
    y_valid_i <= 1'b1;
    y_col_i   <= random_column();
    tick();
    check_value("bias after clear", CheckW'(1'b1), CheckW'(seen_ready));
    y_valid_i <= 1'b0;
    tick();
  endtask

  initial begin
    seed            = SeedInit;
    clk_i           = 1'b0;
    rst_ni          = 1'b0;
    clear_i         = 1'b0;
    fill_i          = 1'b0;
    y_valid_i       = 1'b0;
    ready_i         = 1'b0;
    y_push_enable_i = 1'b0;
    first_load_i    = 1'b0;
    y_width_i       = SIZE_W'(1);
    y_height_i      = SIZE_W'(1);
    z_width_i       = SIZE_W'(1);
    z_height_i      = SIZE_W'(1);
    z_row_i         = '0;
    y_col_i         = '0;
    test_name       = "reset";
    clear_model();
    repeat (2) @(posedge clk_i);
    rst_ni <= 1'b1;
    for (int t = 0; t < int'(NumTiles); t++) begin
      y_width_i    <= random_size(Width);
      y_height_i   <= random_size(Depth);
      z_width_i    <= random_size(Width);
      z_height_i   <= random_size(Depth);
      first_load_i <= (t == 0) || coin(30);
      load_bias();
      reject_in_loaded();
      push_bias();
      fill_rows();
      store_columns();
    end
    clear_tile();
    $display("No errors");
    $finish;
  end

  // Whole-run limit
  initial begin
    repeat (CycleBudget) @(posedge clk_i);
    $display("Timeout: the run did not finish within %0d cycles", CycleBudget);
    $display("Errors found");
    $fatal(1, "cycle budget exhausted");
  end

endmodule : outbuf_tb

// File: outbuf.f
outbuf_pkg.sv
outbuf_ctrl_if.sv
outbuf_scm.sv
outbuf_tile.sv
outbuf_top.sv
outbuf_tb.sv

// File: Makefile
BIN := obj_dir/Voutbuf_tb

.PHONY: all run clean

all: run

$(BIN): outbuf.f outbuf_pkg.sv outbuf_ctrl_if.sv outbuf_scm.sv outbuf_tile.sv \
        outbuf_top.sv outbuf_tb.sv
	verilator --binary --timing --assert -j 0 --top-module outbuf_tb -f outbuf.f

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "^No errors$$"

clean:
	rm -rf obj_dir
